//--- common/axi_pkg.sv
`default_nettype none

package axi_pkg;

  localparam int ID_W   = 4;
  localparam int MIDX_W = 2;
  localparam int SID_W  = ID_W + MIDX_W;
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int LEN_W  = 2;

  typedef logic [ID_W-1:0]   id_t;
  // Master index on top, master ID below
  typedef logic [SID_W-1:0]  sid_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  // Beats minus one
  typedef logic [LEN_W-1:0]  len_t;
  typedef logic [1:0]        resp_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // Write address, master side
  typedef struct packed {
    logic  valid;
    id_t   id;
    addr_t addr;
    len_t  len;
  } aw_m_t;

  // Write address, slave side
  typedef struct packed {
    logic  valid;
    sid_t  id;
    addr_t addr;
    len_t  len;
  } aw_s_t;

  typedef struct packed {
    logic  valid;
    data_t data;
    logic  last;
  } w_t;

  // Write response toward a master
  typedef struct packed {
    logic  valid;
    id_t   id;
    resp_t resp;
  } b_m_t;

  // Write response from a slave
  typedef struct packed {
    logic  valid;
    sid_t  sid;
    resp_t resp;
  } b_s_t;

endpackage

`default_nettype wire

//--- common/bridge_pkg.sv
`default_nettype none

package bridge_pkg;

  typedef logic [1:0] mst_idx_t;

  typedef enum logic [1:0] {S0, S1, S2, SNONE} slv_sel_t;

  // Response return lock
  typedef enum logic [1:0] {LOCK_S0, LOCK_S1, LOCK_S2, LOCK_NO} lock_t;

  typedef enum logic {WP_IDLE, WP_DATA} wp_state_t;

  localparam axi_pkg::addr_t SLV_BASE_0 = 32'h0000_0000;
  localparam axi_pkg::addr_t SLV_BASE_1 = 32'h0001_0000;
  localparam axi_pkg::addr_t SLV_BASE_2 = 32'h0002_0000;
  localparam axi_pkg::addr_t SLV_SPAN   = 32'h0001_0000;

  // Anything above slave 1 lands on slave 2
  function automatic slv_sel_t decode_slave(axi_pkg::addr_t addr);
    slv_sel_t sel;
    if (addr < SLV_BASE_0 + SLV_SPAN) sel = S0;
    else if (addr < SLV_BASE_1 + SLV_SPAN) sel = S1;
    else sel = S2;
    return sel;
  endfunction

  function automatic axi_pkg::addr_t slave_base(slv_sel_t sel);
    axi_pkg::addr_t base;
    case (sel)
      S1:      base = SLV_BASE_1;
      S2:      base = SLV_BASE_2;
      default: base = SLV_BASE_0;
    endcase
    return base;
  endfunction

endpackage

`default_nettype wire

//--- bridge/write_path.sv
`timescale 1ns/1ns
`default_nettype none

module write_path (
  input  logic             clk,
  input  logic             rstn,
  input  axi_pkg::aw_m_t   m_aw [2],
  output logic [1:0]       m_awready,
  input  axi_pkg::w_t      m_w [2],
  output logic [1:0]       m_wready,
  output axi_pkg::aw_s_t   s_aw [3],
  input  logic [2:0]       s_awready,
  output axi_pkg::w_t      s_w [3],
  input  logic [2:0]       s_wready
);

  bridge_pkg::wp_state_t state;
  bridge_pkg::mst_idx_t  gnt_q;
  bridge_pkg::slv_sel_t  slave_sel;
  logic                  last_gnt;
  logic                  aw_busy;

  logic                  sel;
  axi_pkg::aw_m_t        cur_aw;
  bridge_pkg::slv_sel_t  aw_dec;
  logic                  aw_fire;
  logic                  w_fire;

  // Master shown on the address channel
  always_comb begin
    if (aw_busy) sel = gnt_q[0];
    else if (m_aw[0].valid && m_aw[1].valid) sel = ~last_gnt;
    else sel = m_aw[1].valid;
  end

  assign cur_aw = m_aw[sel];
  assign aw_dec = bridge_pkg::decode_slave(cur_aw.addr);

  // Address forward, slaves see the offset within their window
  always_comb begin
    aw_fire   = 1'b0;
    m_awready = '0;
    for (int i = 0; i < 3; i++) begin
      s_aw[i].valid = 1'b0;
      s_aw[i].id    = {bridge_pkg::mst_idx_t'(sel), cur_aw.id};
      s_aw[i].addr  = cur_aw.addr - bridge_pkg::slave_base(aw_dec);
      s_aw[i].len   = cur_aw.len;
      if (state == bridge_pkg::WP_IDLE && aw_dec == bridge_pkg::slv_sel_t'(i)) begin
        s_aw[i].valid = cur_aw.valid;
        aw_fire       = cur_aw.valid && s_awready[i];
      end
    end
    m_awready[sel] = aw_fire;
  end

  // Data steering for the open burst
  always_comb begin
    w_fire   = 1'b0;
    m_wready = '0;
    for (int i = 0; i < 3; i++) begin
      s_w[i]       = m_w[gnt_q[0]];
      s_w[i].valid = 1'b0;
      if (state == bridge_pkg::WP_DATA && slave_sel == bridge_pkg::slv_sel_t'(i)) begin
        s_w[i].valid       = m_w[gnt_q[0]].valid;
        m_wready[gnt_q[0]] = s_wready[i];
        w_fire             = m_w[gnt_q[0]].valid && s_wready[i];
      end
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state     <= bridge_pkg::WP_IDLE;
      gnt_q     <= '0;
      slave_sel <= bridge_pkg::SNONE;
      last_gnt  <= 1'b1;
      aw_busy   <= 1'b0;
    end else begin
      unique case (state)
        bridge_pkg::WP_IDLE: begin
          if (aw_fire) begin
            state     <= bridge_pkg::WP_DATA;
            gnt_q     <= bridge_pkg::mst_idx_t'(sel);
            slave_sel <= aw_dec;
            last_gnt  <= sel;
            aw_busy   <= 1'b0;
          end else if (cur_aw.valid) begin
            // Keep the shown master until its address is taken
            aw_busy <= 1'b1;
            gnt_q   <= bridge_pkg::mst_idx_t'(sel);
          end
        end
        bridge_pkg::WP_DATA: begin
          if (w_fire && m_w[gnt_q[0]].last) begin
            state     <= bridge_pkg::WP_IDLE;
            slave_sel <= bridge_pkg::SNONE;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- bridge/b_return.sv
`timescale 1ns/1ns
`default_nettype none

module b_return (
  input  logic            clk,
  input  logic            rstn,
  input  axi_pkg::b_s_t   s_b [3],
  output logic [2:0]      s_bready,
  output axi_pkg::b_m_t   m_b [2],
  input  logic [1:0]      m_bready
);

  localparam int SID_TOP = $bits(axi_pkg::sid_t) - 1;
  localparam int IDX_W   = $bits(bridge_pkg::mst_idx_t);

  bridge_pkg::lock_t    lock_q;
  bridge_pkg::lock_t    lock_d;
  bridge_pkg::lock_t    last_q;
  logic [2:0]           s_valid;
  logic [2:0]           self_mask;
  axi_pkg::b_s_t        sel_b;
  bridge_pkg::mst_idx_t dest;
  logic                 mst_ready;
  logic                 b_fire;

  // First valid slave after the given one, wrapping back to it last
  function automatic bridge_pkg::lock_t pick_next(bridge_pkg::lock_t after, logic [2:0] v);
    bridge_pkg::lock_t res;
    int                idx;
    res = bridge_pkg::LOCK_NO;
    for (int k = 3; k >= 1; k--) begin
      idx = (int'(after) + k) % 3;
      if (v[idx]) res = bridge_pkg::lock_t'(idx);
    end
    return res;
  endfunction

  always_comb begin
    for (int i = 0; i < 3; i++) begin
      s_valid[i] = s_b[i].valid;
    end
  end

  assign b_fire = sel_b.valid && mst_ready;

  always_comb begin
    self_mask = '0;
    lock_d    = lock_q;
    if (lock_q == bridge_pkg::LOCK_NO) begin
      lock_d = pick_next(last_q, s_valid);
    end else begin
      self_mask[lock_q] = 1'b1;
      // Chain straight to the next pending slave
      if (b_fire) lock_d = pick_next(lock_q, s_valid & ~self_mask);
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      lock_q <= bridge_pkg::LOCK_NO;
      last_q <= bridge_pkg::LOCK_S2;
    end else begin
      lock_q <= lock_d;
      if (lock_q != bridge_pkg::LOCK_NO && b_fire) last_q <= lock_q;
    end
  end

  // Locked slave mux
  always_comb begin
    sel_b    = '0;
    s_bready = '0;
    for (int i = 0; i < 3; i++) begin
      if (lock_q == bridge_pkg::lock_t'(i)) begin
        sel_b       = s_b[i];
        s_bready[i] = mst_ready;
      end
    end
  end

  assign dest = sel_b.sid[SID_TOP -: IDX_W];

  // Route back by the master bits of the ID
  always_comb begin
    mst_ready = 1'b0;
    for (int j = 0; j < 2; j++) begin
      m_b[j] = '0;
      if (dest == bridge_pkg::mst_idx_t'(j)) begin
        m_b[j].valid = sel_b.valid;
        m_b[j].id    = axi_pkg::id_t'(sel_b.sid);
        m_b[j].resp  = sel_b.resp;
        mst_ready    = m_bready[j];
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/mem_slave.sv
`timescale 1ns/1ns
`default_nettype none

module mem_slave #(
  parameter int DEPTH_WORDS = 64
) (
  input  logic            clk,
  input  logic            rstn,
  input  axi_pkg::aw_s_t  aw,
  output logic            awready,
  input  axi_pkg::w_t     w,
  output logic            wready,
  output axi_pkg::b_s_t   b,
  input  logic            bready
);

  localparam int IDX_W = $clog2(DEPTH_WORDS);

  axi_pkg::data_t mem [DEPTH_WORDS];

  logic          burst_open;
  logic          resp_pending;
  logic          err;
  logic [29:0]   wptr;
  axi_pkg::sid_t sid_q;
  logic          aw_hs;
  logic          w_hs;
  logic          in_range;

  assign awready  = !resp_pending && !burst_open;
  assign wready   = burst_open;
  assign aw_hs    = aw.valid && awready;
  assign w_hs     = w.valid && wready;
  assign in_range = wptr < 30'(DEPTH_WORDS);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      burst_open   <= 1'b0;
      resp_pending <= 1'b0;
      err          <= 1'b0;
      wptr         <= '0;
    end else begin
      if (aw_hs) begin
        burst_open <= 1'b1;
        err        <= 1'b0;
        wptr       <= aw.addr[31:2];
      end else if (w_hs) begin
        wptr <= wptr + 30'd1;
        // Sticky for the rest of the burst
        if (!in_range) err <= 1'b1;
        if (w.last) begin
          burst_open   <= 1'b0;
          resp_pending <= 1'b1;
        end
      end
      if (resp_pending && bready) resp_pending <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (w_hs && in_range) mem[wptr[IDX_W-1:0]] <= w.data;
  end

  always_ff @(posedge clk) begin
    if (aw_hs) sid_q <= aw.id;
  end

  always_comb begin
    b.valid = resp_pending;
    b.sid   = sid_q;
    b.resp  = err ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY;
  end

endmodule

`default_nettype wire

//--- verilog/axi_write_bridge.sv
`timescale 1ns/1ns
`default_nettype none

module axi_write_bridge #(
  parameter int DEPTH_0 = 64,
  parameter int DEPTH_1 = 64,
  parameter int DEPTH_2 = 32
) (
  input  logic            clk,
  input  logic            rstn,
  input  axi_pkg::aw_m_t  m_aw [2],
  output logic [1:0]      m_awready,
  input  axi_pkg::w_t     m_w [2],
  output logic [1:0]      m_wready,
  output axi_pkg::b_m_t   m_b [2],
  input  logic [1:0]      m_bready
);

  axi_pkg::aw_s_t s_aw [3];
  logic [2:0]     s_awready;
  axi_pkg::w_t    s_w [3];
  logic [2:0]     s_wready;
  axi_pkg::b_s_t  s_b [3];
  logic [2:0]     s_bready;

  write_path write_path_inst (
    .clk       (clk),
    .rstn      (rstn),
    .m_aw      (m_aw),
    .m_awready (m_awready),
    .m_w       (m_w),
    .m_wready  (m_wready),
    .s_aw      (s_aw),
    .s_awready (s_awready),
    .s_w       (s_w),
    .s_wready  (s_wready)
  );

  b_return b_return_inst (
    .clk      (clk),
    .rstn     (rstn),
    .s_b      (s_b),
    .s_bready (s_bready),
    .m_b      (m_b),
    .m_bready (m_bready)
  );

  mem_slave #(.DEPTH_WORDS(DEPTH_0)) slave_0_inst (
    .clk     (clk),
    .rstn    (rstn),
    .aw      (s_aw[0]),
    .awready (s_awready[0]),
    .w       (s_w[0]),
    .wready  (s_wready[0]),
    .b       (s_b[0]),
    .bready  (s_bready[0])
  );

  mem_slave #(.DEPTH_WORDS(DEPTH_1)) slave_1_inst (
    .clk     (clk),
    .rstn    (rstn),
    .aw      (s_aw[1]),
    .awready (s_awready[1]),
    .w       (s_w[1]),
    .wready  (s_wready[1]),
    .b       (s_b[1]),
    .bready  (s_bready[1])
  );

  // Also takes every address above slave 1's window
  mem_slave #(.DEPTH_WORDS(DEPTH_2)) slave_2_inst (
    .clk     (clk),
    .rstn    (rstn),
    .aw      (s_aw[2]),
    .awready (s_awready[2]),
    .w       (s_w[2]),
    .wready  (s_wready[2]),
    .b       (s_b[2]),
    .bready  (s_bready[2])
  );

endmodule

`default_nettype wire

//--- sim/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
  parameter int PERIOD       = 10,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic rstn
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Release just after an edge so no flop sees it change on the edge
  initial begin
    rstn = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rstn = 1'b1;
  end

endmodule

`default_nettype wire

//--- sim/b_return_chk.sv
`timescale 1ns/1ns
`default_nettype none

module b_return_chk (
  input logic          clk,
  input logic          rstn,
  input axi_pkg::b_s_t s_b [3],
  input logic [2:0]    s_bready,
  input axi_pkg::b_m_t m_b [2],
  input logic [1:0]    m_bready
);

  // Response stays up until the master takes it
  a_hold_0: assert property (@(posedge clk) disable iff (!rstn)
    m_b[0].valid && !m_bready[0] |=> m_b[0].valid)
    else $error("master 0 response dropped before bready");

  a_hold_1: assert property (@(posedge clk) disable iff (!rstn)
    m_b[1].valid && !m_bready[1] |=> m_b[1].valid)
    else $error("master 1 response dropped before bready");

  a_one_ready: assert property (@(posedge clk) disable iff (!rstn) $onehot0(s_bready))
    else $error("more than one slave bready high");

  // Only masters 0 and 1 exist
  for (genvar i = 0; i < 3; i++) begin : g_sid
    a_sid_master: assert property (@(posedge clk) disable iff (!rstn)
      s_b[i].valid |-> !s_b[i].sid[5])
      else $error("slave %0d response tagged with master index above 1", i);
  end

  a_reset_quiet: assert property (@(posedge clk)
    !rstn |-> s_bready == 3'b000 && !m_b[0].valid && !m_b[1].valid)
    else $error("response channel active during reset");

endmodule

`default_nettype wire

//--- sim/axi_write_bridge_tb.sv
`timescale 1ns/1ns
`default_nettype none

module axi_write_bridge_tb;

  localparam int DEPTH_0  = 64;
  localparam int DEPTH_1  = 64;
  localparam int DEPTH_2  = 32;
  localparam int TIMEOUT  = 300;
  localparam int N_RANDOM = 40;

  typedef struct packed {
    axi_pkg::id_t   id;
    axi_pkg::resp_t resp;
  } expect_t;

  logic           clk;
  logic           rstn;
  axi_pkg::aw_m_t m_aw [2];
  logic [1:0]     m_awready;
  axi_pkg::w_t    m_w [2];
  logic [1:0]     m_wready;
  axi_pkg::b_m_t  m_b [2];
  logic [1:0]     m_bready;

  logic [31:0]    lfsr;
  expect_t        exp_q0 [$];
  expect_t        exp_q1 [$];

  tb_clock #(.PERIOD(10), .RESET_CYCLES(8)) tb_clock_inst (.clk(clk), .rstn(rstn));

  axi_write_bridge #(
    .DEPTH_0(DEPTH_0),
    .DEPTH_1(DEPTH_1),
    .DEPTH_2(DEPTH_2)
  ) axi_write_bridge_inst (
    .clk       (clk),
    .rstn      (rstn),
    .m_aw      (m_aw),
    .m_awready (m_awready),
    .m_w       (m_w),
    .m_wready  (m_wready),
    .m_b       (m_b),
    .m_bready  (m_bready)
  );

  bind b_return b_return_chk b_return_chk_inst (
    .clk(clk), .rstn(rstn), .s_b(s_b), .s_bready(s_bready), .m_b(m_b), .m_bready(m_bready)
  );

  task automatic stop_with_failure(input string line);
    $display("%s", line);
    $display("Test failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      val  = {val[30:0], lfsr[0]};
    end
    return val;
  endfunction

  // Slave by address map, then last beat's word against that slave's depth
  function automatic axi_pkg::resp_t expected_resp(input axi_pkg::addr_t addr,
                                                   input axi_pkg::len_t len);
    longint base;
    longint depth;
    longint last_word;
    if (addr < bridge_pkg::SLV_BASE_1) begin
      base  = longint'(bridge_pkg::SLV_BASE_0);
      depth = DEPTH_0;
    end else if (addr < bridge_pkg::SLV_BASE_2) begin
      base  = longint'(bridge_pkg::SLV_BASE_1);
      depth = DEPTH_1;
    end else begin
      base  = longint'(bridge_pkg::SLV_BASE_2);
      depth = DEPTH_2;
    end
    last_word = (longint'(addr) - base) / 4 + longint'(len);
    return (last_word >= depth) ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY;
  endfunction

  task automatic check_idle_bus(input int cycles);
    for (int c = 0; c < cycles; c++) begin
      @(negedge clk);
      assert (m_awready == 2'b00 && m_wready == 2'b00 && !m_b[0].valid && !m_b[1].valid)
        else stop_with_failure($sformatf("** Error at %0t: bus active with no request", $time));
    end
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    while (rstn !== 1'b1) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) stop_with_failure("Timeout: reset was never released");
    end
  endtask

  // Returns on the edge where the handshake happens
  task automatic wait_ready(input int mi, input bit data_chan, input string what);
    int   n;
    logic rdy;
    n   = 0;
    rdy = 1'b0;
    while (!rdy) begin
      @(negedge clk);
      rdy = data_chan ? m_wready[mi] : m_awready[mi];
      n++;
      if (!rdy && n > TIMEOUT)
        stop_with_failure($sformatf("Timeout: master %0d never saw %s", mi, what));
    end
    @(posedge clk);
  endtask

  task automatic wait_no_pending(input int mi);
    int n;
    n = 0;
    while ((mi == 0) ? exp_q0.size() != 0 : exp_q1.size() != 0) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT)
        stop_with_failure($sformatf("Timeout: master %0d response never arrived", mi));
    end
  endtask

  task automatic write_burst(input int mi, input axi_pkg::id_t id, input axi_pkg::addr_t addr,
                             input axi_pkg::len_t len);
    expect_t e;
    wait_no_pending(mi);
    e.id   = id;
    e.resp = expected_resp(addr, len);
    if (mi == 0) exp_q0.push_back(e);
    else exp_q1.push_back(e);
    @(posedge clk);
    #1;
    m_aw[mi] = '{valid: 1'b1, id: id, addr: addr, len: len};
    wait_ready(mi, 1'b0, "awready");
    #1;
    m_aw[mi].valid = 1'b0;
    for (int b = 0; b <= int'(len); b++) begin
      m_w[mi] = '{valid: 1'b1, data: rand_bits(32), last: (b == int'(len))};
      wait_ready(mi, 1'b1, "wready");
      #1;
    end
    m_w[mi].valid = 1'b0;
    m_w[mi].last  = 1'b0;
  endtask

  // Compares every accepted response with the head of that master's queue
  task automatic watch_responses(input int mi);
    expect_t        e;
    logic           took;
    axi_pkg::id_t   id_seen;
    axi_pkg::resp_t resp_seen;
    forever begin
      @(negedge clk);
      took      = m_b[mi].valid && m_bready[mi];
      id_seen   = m_b[mi].id;
      resp_seen = m_b[mi].resp;
      @(posedge clk);
      #1;
      if (took) begin
        assert ((mi == 0) ? exp_q0.size() != 0 : exp_q1.size() != 0)
          else stop_with_failure($sformatf("** Error at %0t: master %0d got an unexpected response",
                                           $time, mi));
        if (mi == 0) e = exp_q0.pop_front();
        else e = exp_q1.pop_front();
        assert (id_seen == e.id && resp_seen == e.resp)
          else stop_with_failure($sformatf(
            "** Error at %0t: master %0d got id %h resp %b, expected id %h resp %b",
            $time, mi, id_seen, resp_seen, e.id, e.resp));
      end
      m_bready[mi] = rand_bits(1) != 32'd0;
    end
  endtask

  task automatic random_master(input int mi, input int count);
    logic [31:0]    r;
    logic [1:0]     region;
    axi_pkg::addr_t addr;
    axi_pkg::id_t   id;
    axi_pkg::len_t  len;
    for (int k = 0; k < count; k++) begin
      repeat (int'(rand_bits(2))) @(posedge clk);
      // Region 3 lies above slave 2
      region = 2'(rand_bits(2));
      r      = rand_bits(6);
      addr   = {14'd0, region, 8'd0, r[5:0], 2'b00};
      id     = axi_pkg::id_t'(rand_bits(4));
      len    = axi_pkg::len_t'(rand_bits(2));
      write_burst(mi, id, addr, len);
    end
  endtask

  initial begin
    lfsr     = 32'h6aaf45b3;
    m_bready = 2'b00;
    for (int i = 0; i < 2; i++) begin
      m_aw[i] = '0;
      m_w[i]  = '0;
    end

    check_idle_bus(6);
    wait_reset_release();
    check_idle_bus(5);

    fork
      watch_responses(0);
      watch_responses(1);
    join_none

    // Single beats to each slave from each master
    write_burst(0, 4'h3, 32'h0000_0010, 2'd0);
    write_burst(0, 4'h5, 32'h0001_0020, 2'd0);
    write_burst(0, 4'h9, 32'h0002_0004, 2'd0);
    write_burst(1, 4'hc, 32'h0000_0100, 2'd0);
    write_burst(1, 4'h6, 32'h0001_0000, 2'd0);
    write_burst(1, 4'h0, 32'h0002_0078, 2'd0);

    // Depth edges and the space above slave 2
    write_burst(0, 4'h1, 32'h0000_00fc, 2'd3);
    write_burst(1, 4'h2, 32'h0002_007c, 2'd1);
    write_burst(0, 4'ha, 32'h0003_0000, 2'd0);
    write_burst(1, 4'hb, 32'h0001_00f0, 2'd3);
    write_burst(0, 4'hf, 32'h0002_0074, 2'd3);

    fork
      random_master(0, N_RANDOM);
      random_master(1, N_RANDOM);
    join

    wait_no_pending(0);
    wait_no_pending(1);
    check_idle_bus(10);
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
common/axi_pkg.sv
common/bridge_pkg.sv
bridge/write_path.sv
bridge/b_return.sv
verilog/mem_slave.sv
verilog/axi_write_bridge.sv
sim/tb_clock.sv
sim/b_return_chk.sv
sim/axi_write_bridge_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module axi_write_bridge_tb -o axi_write_bridge_sim &&
./obj_dir/axi_write_bridge_sim | tee /dev/stderr | grep -q "Test completed successfully" ||
exit 1
